/* noc_datactrl_bridge.f */
rtl/noc_bridge_pkg.sv
rtl/wide_to_narrow.sv
rtl/narrow_to_wide.sv
rtl/noc_data_to_ctrl.sv
rtl/noc_ctrl_to_data.sv
rtl/noc_datactrl_bridge.sv
sim/noc_datactrl_bridge_assertions.sv
sim/tb_noc_datactrl_bridge.sv

/* rtl/narrow_to_wide.sv */
`timescale 1ns/1ps
`default_nettype none

module narrow_to_wide #(
    parameter int in_data_w    = 64,
    parameter int out_data_els = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              src_val,
    input  logic [in_data_w-1:0]              src_data,
    output logic                              src_rdy,
    output logic                              dst_val,
    output logic [in_data_w*out_data_els-1:0] dst_data,
    input  logic                              dst_rdy
);
    localparam int wide_w = in_data_w * out_data_els;
    localparam int cnt_w  = (out_data_els > 1) ? $clog2(out_data_els) : 1;

    logic [wide_w-1:0] word_reg;
    logic [cnt_w-1:0]  count_reg;
    logic              full_reg;
    logic              flit_take;
    logic              last_flit;

    assign src_rdy   = ~full_reg;   // nothing enters until the wide word is taken.
    assign dst_val   = full_reg;
    assign dst_data  = word_reg;
    assign flit_take = src_val & ~full_reg;
    assign last_flit = (count_reg == cnt_w'(out_data_els - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            full_reg  <= 1'b0;
            count_reg <= '0;
        end else if (flit_take) begin
            if (last_flit) begin
                full_reg  <= 1'b1;
                count_reg <= '0;
            end else begin
                count_reg <= count_reg + 1'b1;
            end
        end else if (full_reg & dst_rdy) begin
            full_reg <= 1'b0;
        end
    end

    // the first flit is shifted up until it sits in the top slice.
    always_ff @(posedge clk) begin
        if (flit_take) begin
            word_reg <= {word_reg[wide_w-in_data_w-1:0], src_data};
        end
    end

endmodule

`default_nettype wire

/* rtl/noc_bridge_pkg.sv */
`default_nettype none

package noc_bridge_pkg;

    parameter int noc_data_w  = 256;
    parameter int ctrl_data_w = 64;
    parameter int msg_len_w   = 8;

    typedef struct packed {
        logic [7:0]            dst_chip_id;
        logic [7:0]            dst_x;
        logic [7:0]            dst_y;
        logic [3:0]            dst_fbits;
        logic [msg_len_w-1:0]  msg_len;        // data flits after the header.
        logic [7:0]            src_chip_id;
        logic [7:0]            src_x;
        logic [7:0]            src_y;
        logic [3:0]            src_fbits;
        logic [msg_len_w-1:0]  metadata_flits;
        logic [noc_data_w-73:0] pad;
    } wide_hdr_t;

    // the top 36 bits line up with the top of wide_hdr_t.
    typedef struct packed {
        logic [7:0]             dst_chip_id;
        logic [7:0]             dst_x;
        logic [7:0]             dst_y;
        logic [3:0]             dst_fbits;
        logic [msg_len_w-1:0]   msg_len;       // counts the misc header too.
        logic [ctrl_data_w-37:0] pad;
    } routing_hdr_t;

    typedef struct packed {
        logic [7:0]             src_chip_id;
        logic [7:0]             src_x;
        logic [7:0]             src_y;
        logic [3:0]             src_fbits;
        logic [msg_len_w-1:0]   metadata_flits;
        logic [ctrl_data_w-37:0] pad;
    } misc_hdr_t;

    typedef enum logic [1:0] {dtc_ready, dtc_misc_hdr, dtc_pass_data, dtc_drain} dtc_state_e;

    typedef enum logic [1:0] {ctd_route_hdr, ctd_misc_hdr, ctd_send_hdr, ctd_pass_data} ctd_state_e;

endpackage

`default_nettype wire

/* rtl/noc_ctrl_to_data.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_ctrl_to_data
    import noc_bridge_pkg::*;
#(
    parameter int flit_els = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   src_noc_ctd_val,
    input  logic [ctrl_data_w-1:0] src_noc_ctd_data,
    output logic                   noc_ctd_src_rdy,
    output logic                   noc_ctd_dst_val,
    output logic [noc_data_w-1:0]  noc_ctd_dst_data,
    input  logic                   dst_noc_ctd_rdy
);
    localparam int flit_shift = $clog2(flit_els);

    ctd_state_e            state_reg;
    ctd_state_e            state_next;
    routing_hdr_t          route_reg;
    misc_hdr_t             misc_reg;
    wide_hdr_t             wide_hdr;
    logic [msg_len_w-1:0]  count_reg;
    logic                  hdr_sent;
    logic                  data_take;
    logic                  narrow_val;
    logic                  narrow_rdy;
    logic                  wide_val;
    logic                  wide_rdy;
    logic [noc_data_w-1:0] wide_data;

    assign hdr_sent  = (state_reg == ctd_send_hdr) & dst_noc_ctd_rdy;
    assign data_take = wide_val & wide_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ctd_route_hdr;
            count_reg <= '0;
        end else begin
            state_reg <= state_next;
            if (hdr_sent) begin
                count_reg <= wide_hdr.msg_len;
            end else if (data_take) begin
                count_reg <= count_reg - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_reg == ctd_route_hdr && src_noc_ctd_val) begin
            route_reg <= src_noc_ctd_data;
        end
        if (state_reg == ctd_misc_hdr && src_noc_ctd_val) begin
            misc_reg <= src_noc_ctd_data;
        end
    end

    // the narrow length counts the misc header, so drop it before dividing.
    always_comb begin
        wide_hdr                = '0;
        wide_hdr.dst_chip_id    = route_reg.dst_chip_id;
        wide_hdr.dst_x          = route_reg.dst_x;
        wide_hdr.dst_y          = route_reg.dst_y;
        wide_hdr.dst_fbits      = route_reg.dst_fbits;
        wide_hdr.msg_len        = (route_reg.msg_len - 1'b1) >> flit_shift;
        wide_hdr.src_chip_id    = misc_reg.src_chip_id;
        wide_hdr.src_x          = misc_reg.src_x;
        wide_hdr.src_y          = misc_reg.src_y;
        wide_hdr.src_fbits      = misc_reg.src_fbits;
        wide_hdr.metadata_flits = misc_reg.metadata_flits >> flit_shift;
    end

    always_comb begin
        state_next       = state_reg;
        noc_ctd_src_rdy  = 1'b0;
        noc_ctd_dst_val  = 1'b0;
        noc_ctd_dst_data = '0;
        narrow_val       = 1'b0;
        wide_rdy         = 1'b0;
        case (state_reg)
            ctd_route_hdr: begin
                noc_ctd_src_rdy = 1'b1;
                if (src_noc_ctd_val) begin
                    state_next = ctd_misc_hdr;
                end
            end
            ctd_misc_hdr: begin
                noc_ctd_src_rdy = 1'b1;
                if (src_noc_ctd_val) begin
                    state_next = ctd_send_hdr;
                end
            end
            ctd_send_hdr: begin
                noc_ctd_dst_val  = 1'b1;
                noc_ctd_dst_data = wide_hdr;
                if (hdr_sent) begin
                    state_next = (wide_hdr.msg_len == '0) ? ctd_route_hdr : ctd_pass_data;
                end
            end
            default: begin
                narrow_val       = src_noc_ctd_val;
                noc_ctd_src_rdy  = narrow_rdy;
                noc_ctd_dst_val  = wide_val;
                noc_ctd_dst_data = wide_data;
                wide_rdy         = dst_noc_ctd_rdy;
                if (data_take && count_reg == msg_len_w'(1)) begin
                    state_next = ctd_route_hdr;
                end
            end
        endcase
    end

    narrow_to_wide #(
        .in_data_w    (ctrl_data_w),
        .out_data_els (flit_els)
    ) ntw (
        .clk      (clk),
        .rst      (rst),
        .src_val  (narrow_val),
        .src_data (src_noc_ctd_data),
        .src_rdy  (narrow_rdy),
        .dst_val  (wide_val),
        .dst_data (wide_data),
        .dst_rdy  (wide_rdy)
    );

endmodule

`default_nettype wire

/* rtl/noc_data_to_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_data_to_ctrl
    import noc_bridge_pkg::*;
#(
    parameter int flit_els = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   src_noc_dtc_val,
    input  logic [noc_data_w-1:0]  src_noc_dtc_data,
    output logic                   noc_dtc_src_rdy,
    output logic                   noc_dtc_dst_val,
    output logic [ctrl_data_w-1:0] noc_dtc_dst_data,
    input  logic                   dst_noc_dtc_rdy
);
    localparam int flit_shift = $clog2(flit_els);

    dtc_state_e             state_reg;
    dtc_state_e             state_next;
    wide_hdr_t              wide_hdr;
    wide_hdr_t              hdr_reg;
    routing_hdr_t           routing_hdr;
    misc_hdr_t              misc_hdr;
    logic [msg_len_w-1:0]   count_reg;
    logic                   hdr_take;
    logic                   data_take;
    logic                   wide_val;
    logic                   wide_last;
    logic                   wide_rdy;
    logic                   narrow_val;
    logic                   narrow_last;
    logic                   narrow_rdy;
    logic [ctrl_data_w-1:0] narrow_data;

    assign wide_hdr  = src_noc_dtc_data;
    assign hdr_take  = (state_reg == dtc_ready) & src_noc_dtc_val & dst_noc_dtc_rdy;
    assign data_take = wide_val & wide_rdy;
    assign wide_last = (count_reg == msg_len_w'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= dtc_ready;
            count_reg <= '0;
        end else begin
            state_reg <= state_next;
            if (hdr_take) begin
                count_reg <= wide_hdr.msg_len;
            end else if (data_take) begin
                count_reg <= count_reg - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            hdr_reg <= wide_hdr;
        end
    end

    always_comb begin
        state_next      = state_reg;
        noc_dtc_dst_val = 1'b0;
        noc_dtc_src_rdy = 1'b0;
        wide_val        = 1'b0;
        narrow_rdy      = 1'b0;
        case (state_reg)
            dtc_ready: begin
                noc_dtc_dst_val = src_noc_dtc_val;   // header goes straight through.
                noc_dtc_src_rdy = dst_noc_dtc_rdy;
                if (hdr_take) begin
                    state_next = dtc_misc_hdr;
                end
            end
            dtc_misc_hdr: begin
                noc_dtc_dst_val = 1'b1;
                if (dst_noc_dtc_rdy) begin
                    state_next = (count_reg == '0) ? dtc_ready : dtc_pass_data;
                end
            end
            dtc_pass_data: begin
                noc_dtc_dst_val = narrow_val;
                narrow_rdy      = dst_noc_dtc_rdy;
                wide_val        = src_noc_dtc_val;
                noc_dtc_src_rdy = wide_rdy;
                if (data_take & wide_last) begin
                    state_next = dtc_drain;
                end
            end
            default: begin
                noc_dtc_dst_val = narrow_val;
                narrow_rdy      = dst_noc_dtc_rdy;
                if (narrow_val & narrow_rdy & narrow_last) begin
                    state_next = dtc_ready;
                end
            end
        endcase
    end

    always_comb begin
        routing_hdr         = src_noc_dtc_data[noc_data_w-1 -: ctrl_data_w];
        routing_hdr.msg_len = msg_len_w'((wide_hdr.msg_len << flit_shift) + 1'b1);
        misc_hdr                = '0;
        misc_hdr.src_chip_id    = hdr_reg.src_chip_id;
        misc_hdr.src_x          = hdr_reg.src_x;
        misc_hdr.src_y          = hdr_reg.src_y;
        misc_hdr.src_fbits      = hdr_reg.src_fbits;
        misc_hdr.metadata_flits = msg_len_w'(hdr_reg.metadata_flits << flit_shift);
    end

    always_comb begin
        case (state_reg)
            dtc_ready:    noc_dtc_dst_data = routing_hdr;
            dtc_misc_hdr: noc_dtc_dst_data = misc_hdr;
            default:      noc_dtc_dst_data = narrow_data;
        endcase
    end

    wide_to_narrow #(
        .out_data_w  (ctrl_data_w),
        .in_data_els (flit_els)
    ) wtn (
        .clk      (clk),
        .rst      (rst),
        .src_val  (wide_val),
        .src_data (src_noc_dtc_data),
        .src_last (wide_last),
        .src_rdy  (wide_rdy),
        .dst_val  (narrow_val),
        .dst_data (narrow_data),
        .dst_last (narrow_last),
        .dst_rdy  (narrow_rdy)
    );

endmodule

`default_nettype wire

/* rtl/noc_datactrl_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_datactrl_bridge
    import noc_bridge_pkg::*;
#(
    parameter int flit_els = 4     // narrow flits per wide flit.
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wide_in_val,
    input  logic [noc_data_w-1:0]  wide_in_data,
    output logic                   wide_in_rdy,
    output logic                   ctrl_out_val,
    output logic [ctrl_data_w-1:0] ctrl_out_data,
    input  logic                   ctrl_out_rdy,
    input  logic                   ctrl_in_val,
    input  logic [ctrl_data_w-1:0] ctrl_in_data,
    output logic                   ctrl_in_rdy,
    output logic                   wide_out_val,
    output logic [noc_data_w-1:0]  wide_out_data,
    input  logic                   wide_out_rdy
);

    noc_data_to_ctrl #(
        .flit_els (flit_els)
    ) u_data_to_ctrl (
        .clk              (clk),
        .rst              (rst),
        .src_noc_dtc_val  (wide_in_val),
        .src_noc_dtc_data (wide_in_data),
        .noc_dtc_src_rdy  (wide_in_rdy),
        .noc_dtc_dst_val  (ctrl_out_val),
        .noc_dtc_dst_data (ctrl_out_data),
        .dst_noc_dtc_rdy  (ctrl_out_rdy)
    );

    noc_ctrl_to_data #(
        .flit_els (flit_els)
    ) u_ctrl_to_data (
        .clk              (clk),
        .rst              (rst),
        .src_noc_ctd_val  (ctrl_in_val),
        .src_noc_ctd_data (ctrl_in_data),
        .noc_ctd_src_rdy  (ctrl_in_rdy),
        .noc_ctd_dst_val  (wide_out_val),
        .noc_ctd_dst_data (wide_out_data),
        .dst_noc_ctd_rdy  (wide_out_rdy)
    );

endmodule

`default_nettype wire

/* rtl/wide_to_narrow.sv */
`timescale 1ns/1ps
`default_nettype none

module wide_to_narrow #(
    parameter int out_data_w  = 64,
    parameter int in_data_els = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                src_val,
    input  logic [out_data_w*in_data_els-1:0]   src_data,
    input  logic                                src_last,
    output logic                                src_rdy,
    output logic                                dst_val,
    output logic [out_data_w-1:0]               dst_data,
    output logic                                dst_last,
    input  logic                                dst_rdy
);
    localparam int wide_w = out_data_w * in_data_els;
    localparam int cnt_w  = (in_data_els > 1) ? $clog2(in_data_els) : 1;

    logic [wide_w-1:0] word_reg;
    logic [cnt_w-1:0]  slice_reg;
    logic              last_reg;
    logic              full_reg;
    logic              final_slice;
    logic              slice_take;

    assign final_slice = (slice_reg == cnt_w'(in_data_els - 1));
    assign slice_take  = full_reg & dst_rdy;

    // a new word may enter in the cycle the final slice leaves.
    assign src_rdy  = ~full_reg | (slice_take & final_slice);
    assign dst_val  = full_reg;
    assign dst_data = word_reg[wide_w-1 -: out_data_w];  // slices leave from the top.
    assign dst_last = last_reg & final_slice;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_reg  <= 1'b0;
            slice_reg <= '0;
            last_reg  <= 1'b0;
        end else if (src_val & src_rdy) begin
            full_reg  <= 1'b1;
            slice_reg <= '0;
            last_reg  <= src_last;
        end else if (slice_take) begin
            full_reg  <= ~final_slice;
            slice_reg <= slice_reg + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (src_val & src_rdy) begin
            word_reg <= src_data;
        end else if (slice_take) begin
            word_reg <= word_reg << out_data_w;
        end
    end

endmodule

`default_nettype wire

/* sim/noc_datactrl_bridge_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_datactrl_bridge_assertions
    import noc_bridge_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   ctrl_out_val,
    input logic [ctrl_data_w-1:0] ctrl_out_data,
    input logic                   ctrl_out_rdy,
    input logic                   wide_out_val,
    input logic [noc_data_w-1:0]  wide_out_data,
    input logic                   wide_out_rdy
);
    int fail_count = 0;

    ctrl_out_hold: assert property (@(posedge clk) disable iff (rst)
        ctrl_out_val && !ctrl_out_rdy |=> ctrl_out_val && $stable(ctrl_out_data))
        else begin
            fail_count++;
            $error("ctrl_out dropped or changed a stalled flit");
        end

    wide_out_hold: assert property (@(posedge clk) disable iff (rst)
        wide_out_val && !wide_out_rdy |=> wide_out_val && $stable(wide_out_data))
        else begin
            fail_count++;
            $error("wide_out dropped or changed a stalled flit");
        end

    // nothing is offered on the outputs right after reset.
    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !ctrl_out_val && !wide_out_val)
        else begin
            fail_count++;
            $error("an output valid was high in the cycle after reset");
        end

endmodule

bind noc_datactrl_bridge noc_datactrl_bridge_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .ctrl_out_val  (ctrl_out_val),
    .ctrl_out_data (ctrl_out_data),
    .ctrl_out_rdy  (ctrl_out_rdy),
    .wide_out_val  (wide_out_val),
    .wide_out_data (wide_out_data),
    .wide_out_rdy  (wide_out_rdy)
);

`default_nettype wire

/* sim/tb_noc_datactrl_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_datactrl_bridge
    import noc_bridge_pkg::*;
();
    localparam int num_msgs   = 12;
    localparam int wait_limit = 500;

    logic                   clk;
    logic                   rst;
    logic                   wide_in_val;
    logic [noc_data_w-1:0]  wide_in_data;
    logic                   wide_in_rdy;
    logic                   ctrl_out_val;
    logic [ctrl_data_w-1:0] ctrl_out_data;
    logic                   ctrl_out_rdy;
    logic                   ctrl_in_val;
    logic [ctrl_data_w-1:0] ctrl_in_data;
    logic                   ctrl_in_rdy;
    logic                   wide_out_val;
    logic [noc_data_w-1:0]  wide_out_data;
    logic                   wide_out_rdy;

    logic [31:0]            rng_state;
    int                     error_count;
    int                     check_count;
    logic [noc_data_w-1:0]  wide_stim[$];
    int                     wide_gap[$];
    logic [ctrl_data_w-1:0] narrow_stim[$];
    int                     narrow_gap[$];
    logic [ctrl_data_w-1:0] ctrl_exp[$];
    logic [noc_data_w-1:0]  wide_exp[$];

    noc_datactrl_bridge #(
        .flit_els (4)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .wide_in_val   (wide_in_val),
        .wide_in_data  (wide_in_data),
        .wide_in_rdy   (wide_in_rdy),
        .ctrl_out_val  (ctrl_out_val),
        .ctrl_out_data (ctrl_out_data),
        .ctrl_out_rdy  (ctrl_out_rdy),
        .ctrl_in_val   (ctrl_in_val),
        .ctrl_in_data  (ctrl_in_data),
        .ctrl_in_rdy   (ctrl_in_rdy),
        .wide_out_val  (wide_out_val),
        .wide_out_data (wide_out_data),
        .wide_out_rdy  (wide_out_rdy)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [noc_data_w-1:0] random_wide();
        logic [noc_data_w-1:0] w;
        for (int i = 0; i < noc_data_w / 32; i++) begin
            w[32*i +: 32] = next_random();
        end
        return w;
    endfunction

    function automatic int random_gap();
        return int'(next_random() >> 30) / 2;   // an idle cycle before about half the flits.
    endfunction

    task automatic check_value(input string name, input logic [noc_data_w-1:0] actual,
                               input logic [noc_data_w-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic build_wide_msg(input int len);
        wide_hdr_t             hdr;
        routing_hdr_t          route;
        misc_hdr_t             misc;
        logic [noc_data_w-1:0] word;
        hdr         = random_wide();
        hdr.msg_len = msg_len_w'(len);
        wide_stim.push_back(hdr);
        wide_gap.push_back(random_gap());
        // the routing header is the top slice of the wide header with a rescaled length.
        route         = hdr[noc_data_w-1 -: ctrl_data_w];
        route.msg_len = msg_len_w'(4 * len + 1);
        misc                = '0;
        misc.src_chip_id    = hdr.src_chip_id;
        misc.src_x          = hdr.src_x;
        misc.src_y          = hdr.src_y;
        misc.src_fbits      = hdr.src_fbits;
        misc.metadata_flits = msg_len_w'(4 * hdr.metadata_flits);
        ctrl_exp.push_back(route);
        ctrl_exp.push_back(misc);
        for (int i = 0; i < len; i++) begin
            word = random_wide();
            wide_stim.push_back(word);
            wide_gap.push_back(random_gap());
            for (int j = 0; j < 4; j++) begin
                ctrl_exp.push_back(word[noc_data_w-1-ctrl_data_w*j -: ctrl_data_w]);
            end
        end
    endtask

    task automatic build_narrow_msg(input int k);
        routing_hdr_t           route;
        misc_hdr_t              misc;
        wide_hdr_t              hdr;
        logic [noc_data_w-1:0]  bits;
        logic [noc_data_w-1:0]  word;
        logic [ctrl_data_w-1:0] slice;
        bits          = random_wide();
        route         = bits[ctrl_data_w-1:0];
        route.msg_len = msg_len_w'(4 * k + 1);   // data flits plus the misc header.
        misc          = bits[2*ctrl_data_w-1:ctrl_data_w];
        narrow_stim.push_back(route);
        narrow_gap.push_back(random_gap());
        narrow_stim.push_back(misc);
        narrow_gap.push_back(random_gap());
        hdr                = '0;
        hdr.dst_chip_id    = route.dst_chip_id;
        hdr.dst_x          = route.dst_x;
        hdr.dst_y          = route.dst_y;
        hdr.dst_fbits      = route.dst_fbits;
        hdr.msg_len        = msg_len_w'(k);
        hdr.src_chip_id    = misc.src_chip_id;
        hdr.src_x          = misc.src_x;
        hdr.src_y          = misc.src_y;
        hdr.src_fbits      = misc.src_fbits;
        hdr.metadata_flits = misc.metadata_flits >> 2;
        wide_exp.push_back(hdr);
        for (int i = 0; i < k; i++) begin
            bits = random_wide();
            for (int j = 0; j < 4; j++) begin
                slice = bits[ctrl_data_w*j +: ctrl_data_w];
                narrow_stim.push_back(slice);
                narrow_gap.push_back(random_gap());
                word[noc_data_w-1-ctrl_data_w*j -: ctrl_data_w] = slice;
            end
            wide_exp.push_back(word);
        end
    endtask

    task automatic drive_wide_source();
        int cnt;
        for (int i = 0; i < wide_stim.size(); i++) begin
            repeat (wide_gap[i]) begin
                @(posedge clk);
                #1;
            end
            wide_in_val  = 1'b1;
            wide_in_data = wide_stim[i];
            cnt = 0;
            @(negedge clk);
            while (!wide_in_rdy) begin
                cnt++;
                if (cnt > wait_limit) begin
                    timed_out("the wide input to accept a flit");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            wide_in_val = 1'b0;
        end
    endtask

    task automatic drive_narrow_source();
        int cnt;
        for (int i = 0; i < narrow_stim.size(); i++) begin
            repeat (narrow_gap[i]) begin
                @(posedge clk);
                #1;
            end
            ctrl_in_val  = 1'b1;
            ctrl_in_data = narrow_stim[i];
            cnt = 0;
            @(negedge clk);
            while (!ctrl_in_rdy) begin
                cnt++;
                if (cnt > wait_limit) begin
                    timed_out("the narrow input to accept a flit");
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            ctrl_in_val = 1'b0;
        end
    endtask

    // ready levels change 1 ns after each rising edge.
    always @(posedge clk) begin
        #1;
        ctrl_out_rdy = (next_random() >> 30) != 0;
        wide_out_rdy = (next_random() >> 30) != 0;
    end

    always @(negedge clk) begin
        if (!rst && ctrl_out_val && ctrl_out_rdy) begin
            if (ctrl_exp.size() == 0) begin
                error_count++;
                $display("ctrl_out delivered a flit that no message accounts for");
            end else begin
                check_value("ctrl_out_data", ctrl_out_data, ctrl_exp.pop_front());
            end
        end
        if (!rst && wide_out_val && wide_out_rdy) begin
            if (wide_exp.size() == 0) begin
                error_count++;
                $display("wide_out delivered a flit that no message accounts for");
            end else begin
                check_value("wide_out_data", wide_out_data, wide_exp.pop_front());
            end
        end
    end

    initial begin
        int cnt;
        clk          = 1'b0;
        rst          = 1'b1;
        wide_in_val  = 1'b0;
        wide_in_data = '0;
        ctrl_in_val  = 1'b0;
        ctrl_in_data = '0;
        ctrl_out_rdy = 1'b0;
        wide_out_rdy = 1'b0;
        rng_state    = 32'd36;
        error_count  = 0;
        check_count  = 0;
        build_wide_msg(0);   // a header-only message gives a routing length of 1.
        build_wide_msg(5);
        build_narrow_msg(0);
        build_narrow_msg(5);
        for (int m = 0; m < num_msgs; m++) begin
            build_wide_msg(int'(next_random() >> 16) % 6);
            build_narrow_msg(int'(next_random() >> 16) % 6);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("ctrl_out_val", ctrl_out_val, 1'b0);
            check_value("wide_out_val", wide_out_val, 1'b0);
        end
        @(posedge clk);
        #1;
        fork
            drive_wide_source();
            drive_narrow_source();
        join
        cnt = 0;
        while (ctrl_exp.size() != 0 || wide_exp.size() != 0) begin
            cnt++;
            if (cnt > wait_limit) begin
                timed_out("the last expected output flits");
            end
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        error_count = error_count + dut.u_assertions.fail_count;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
